//--- src/dccm_pkg.sv
// ##########################################################
// Geometry of the load/store unit data memory (DCCM)
// Shared by the steering, bank RAM and read alignment blocks
// Byte address = { index, bank, byte offset }
// ##########################################################

package dccm_pkg;

   // Byte address width, 4 KB in total
   localparam int DCCM_BITS = 12;

   // Bytes held in one bank word
   localparam int DCCM_BYTE_WIDTH = 4;

   // Byte offset inside a word, lowest address bits
   localparam int DCCM_WIDTH_BITS = $clog2(DCCM_BYTE_WIDTH);

   // Banks interleaved on the word address
   localparam int DCCM_NUM_BANKS = 4;

   // Bank select sits right above the byte offset
   localparam int DCCM_BANK_BITS = $clog2(DCCM_NUM_BANKS);

   // Row index within one bank, whatever is left of the address
   localparam int DCCM_INDEX_BITS = DCCM_BITS - DCCM_BANK_BITS - DCCM_WIDTH_BITS;

   // Rows per bank
   localparam int DCCM_INDEX_DEPTH = 1 << DCCM_INDEX_BITS;

   // Data word, no ECC bits
   localparam int DCCM_DATA_WIDTH = DCCM_BYTE_WIDTH * 8;

   // Low bit of the index field
   localparam int DCCM_INDEX_LSB = DCCM_WIDTH_BITS + DCCM_BANK_BITS;

endpackage

//--- src/dccm_bank_steer.sv
// ##########################################################
// Bank steering for the DCCM
// Turns lo/hi read and write byte addresses into per-bank
// enables, row index and write data; purely combinational
// ##########################################################

`timescale 1ns/100ps

module dccm_bank_steer (
   input  logic                                 dccm_wren,
   input  logic                                 dccm_rden,
   input  logic [dccm_pkg::DCCM_BITS-1:0]       dccm_wr_addr_lo,
   input  logic [dccm_pkg::DCCM_BITS-1:0]       dccm_wr_addr_hi,
   input  logic [dccm_pkg::DCCM_BITS-1:0]       dccm_rd_addr_lo,
   input  logic [dccm_pkg::DCCM_BITS-1:0]       dccm_rd_addr_hi,
   input  logic [dccm_pkg::DCCM_DATA_WIDTH-1:0] dccm_wr_data_lo,
   input  logic [dccm_pkg::DCCM_DATA_WIDTH-1:0] dccm_wr_data_hi,

   output logic [dccm_pkg::DCCM_NUM_BANKS-1:0]  wren_bank,
   output logic [dccm_pkg::DCCM_NUM_BANKS-1:0]  rden_bank,
   output logic [dccm_pkg::DCCM_NUM_BANKS-1:0]  clken_bank,
   output logic [dccm_pkg::DCCM_NUM_BANKS-1:0][dccm_pkg::DCCM_INDEX_BITS-1:0] addr_bank,
   output logic [dccm_pkg::DCCM_NUM_BANKS-1:0][dccm_pkg::DCCM_DATA_WIDTH-1:0] wr_data_bank
);

   import dccm_pkg::*;

   // Bank fields of the four addresses
   logic [DCCM_BANK_BITS-1:0]  wr_bank_lo;
   logic [DCCM_BANK_BITS-1:0]  wr_bank_hi;
   logic [DCCM_BANK_BITS-1:0]  rd_bank_lo;
   logic [DCCM_BANK_BITS-1:0]  rd_bank_hi;

   // Row index fields of the four addresses
   logic [DCCM_INDEX_BITS-1:0] wr_idx_lo;
   logic [DCCM_INDEX_BITS-1:0] wr_idx_hi;
   logic [DCCM_INDEX_BITS-1:0] rd_idx_lo;
   logic [DCCM_INDEX_BITS-1:0] rd_idx_hi;

   // Access crosses a word boundary
   logic                       wr_unaligned;
   logic                       rd_unaligned;

   // Per-bank address hits
   logic [DCCM_NUM_BANKS-1:0]  wr_hit_lo;
   logic [DCCM_NUM_BANKS-1:0]  wr_hit_hi;
   logic [DCCM_NUM_BANKS-1:0]  rd_hit_lo;
   logic [DCCM_NUM_BANKS-1:0]  rd_hit_hi;

   // Per-bank row index of each request, before write priority
   logic [DCCM_NUM_BANKS-1:0][DCCM_INDEX_BITS-1:0] wr_idx_bank;
   logic [DCCM_NUM_BANKS-1:0][DCCM_INDEX_BITS-1:0] rd_idx_bank;

   // Field split: offset in the low bits, bank above it, index on top
   assign wr_bank_lo = dccm_wr_addr_lo[DCCM_WIDTH_BITS +: DCCM_BANK_BITS];
   assign wr_bank_hi = dccm_wr_addr_hi[DCCM_WIDTH_BITS +: DCCM_BANK_BITS];
   assign rd_bank_lo = dccm_rd_addr_lo[DCCM_WIDTH_BITS +: DCCM_BANK_BITS];
   assign rd_bank_hi = dccm_rd_addr_hi[DCCM_WIDTH_BITS +: DCCM_BANK_BITS];

   assign wr_idx_lo  = dccm_wr_addr_lo[DCCM_INDEX_LSB +: DCCM_INDEX_BITS];
   assign wr_idx_hi  = dccm_wr_addr_hi[DCCM_INDEX_LSB +: DCCM_INDEX_BITS];
   assign rd_idx_lo  = dccm_rd_addr_lo[DCCM_INDEX_LSB +: DCCM_INDEX_BITS];
   assign rd_idx_hi  = dccm_rd_addr_hi[DCCM_INDEX_LSB +: DCCM_INDEX_BITS];

   // Different banks for lo and hi means two words in one cycle
   assign wr_unaligned = (wr_bank_lo != wr_bank_hi);
   assign rd_unaligned = (rd_bank_lo != rd_bank_hi);

   for (genvar i = 0; i < DCCM_NUM_BANKS; i++) begin : g_bank

      // Decode of each bank field onto this bank
      assign wr_hit_lo[i] = (wr_bank_lo == DCCM_BANK_BITS'(i));
      assign wr_hit_hi[i] = (wr_bank_hi == DCCM_BANK_BITS'(i));
      assign rd_hit_lo[i] = (rd_bank_lo == DCCM_BANK_BITS'(i));
      assign rd_hit_hi[i] = (rd_bank_hi == DCCM_BANK_BITS'(i));

      // Either half of the request lands here
      assign wren_bank[i] = dccm_wren & (wr_hit_lo[i] | wr_hit_hi[i]);
      assign rden_bank[i] = dccm_rden & (rd_hit_lo[i] | rd_hit_hi[i]);

      // Macro runs only when something targets it
      assign clken_bank[i] = wren_bank[i] | rden_bank[i];

      // Hi half only owns the bank when it really is a second word
      assign wr_idx_bank[i] = (wr_hit_hi[i] & wr_unaligned) ? wr_idx_hi : wr_idx_lo;
      assign rd_idx_bank[i] = (rd_hit_hi[i] & rd_unaligned) ? rd_idx_hi : rd_idx_lo;

      // Write wins the single port
      assign addr_bank[i] = wren_bank[i] ? wr_idx_bank[i] : rd_idx_bank[i];

      // Same lo/hi choice for the data word
      assign wr_data_bank[i] = (wr_hit_hi[i] & wr_unaligned) ? dccm_wr_data_hi
                                                             : dccm_wr_data_lo;
   end : g_bank

endmodule

//--- src/dccm_sram_bank.sv
// ##########################################################
// Behavioral single-port RAM for one DCCM bank
// Stands in for a vendor macro: chip enable, write enable,
// registered read data one cycle after the enable
// ##########################################################

`timescale 1ns/100ps

module dccm_sram_bank (
   input  logic                                 clk,
   input  logic                                 me,
   input  logic                                 we,
   input  logic [dccm_pkg::DCCM_INDEX_BITS-1:0] adr,
   input  logic [dccm_pkg::DCCM_DATA_WIDTH-1:0] d,
   output logic [dccm_pkg::DCCM_DATA_WIDTH-1:0] q
);

   import dccm_pkg::*;

   // Storage array, contents survive reset
   logic [DCCM_DATA_WIDTH-1:0] mem [DCCM_INDEX_DEPTH];

   // Write port
   always_ff @(posedge clk) begin
      if (me && we) begin
         mem[adr] <= d;
      end
   end

   // Read register
   // Like the macro, q is not defined on a write cycle
   // and keeps its value while the bank is idle
   always_ff @(posedge clk) begin
      if (me) begin
         if (we) begin
            q <= 'x;
         end else begin
            q <= mem[adr];
         end
      end
   end

endmodule

//--- src/dccm_rd_align.sv
// ##########################################################
// Read data alignment for the DCCM
// Keeps the bank fields of the lo and hi read addresses for
// one cycle and uses them to pick the two words out of the
// bank outputs
// ##########################################################

`timescale 1ns/100ps

module dccm_rd_align (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic [dccm_pkg::DCCM_BITS-1:0]       dccm_rd_addr_lo,
   input  logic [dccm_pkg::DCCM_BITS-1:0]       dccm_rd_addr_hi,
   input  logic [dccm_pkg::DCCM_NUM_BANKS-1:0][dccm_pkg::DCCM_DATA_WIDTH-1:0] bank_dout,
   output logic [dccm_pkg::DCCM_DATA_WIDTH-1:0] dccm_rd_data_lo,
   output logic [dccm_pkg::DCCM_DATA_WIDTH-1:0] dccm_rd_data_hi
);

   import dccm_pkg::*;

   // Bank fields of the current read request
   logic [DCCM_BANK_BITS-1:0] rd_bank_lo;
   logic [DCCM_BANK_BITS-1:0] rd_bank_hi;

   // Same fields, lined up with the RAM output
   logic [DCCM_BANK_BITS-1:0] rd_bank_lo_q;
   logic [DCCM_BANK_BITS-1:0] rd_bank_hi_q;

   assign rd_bank_lo = dccm_rd_addr_lo[DCCM_WIDTH_BITS +: DCCM_BANK_BITS];
   assign rd_bank_hi = dccm_rd_addr_hi[DCCM_WIDTH_BITS +: DCCM_BANK_BITS];

   // Sampled every cycle
   // only meaningful the cycle after a read
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_bank_lo_q <= '0;
         rd_bank_hi_q <= '0;
      end else begin
         rd_bank_lo_q <= rd_bank_lo;
         rd_bank_hi_q <= rd_bank_hi;
      end
   end

   // Bank output mux, lo word
   assign dccm_rd_data_lo = bank_dout[rd_bank_lo_q];

   // Hi word, equals lo on an aligned read
   assign dccm_rd_data_hi = bank_dout[rd_bank_hi_q];

endmodule

//--- src/lsu_dccm_mem.sv
// ##########################################################
// DCCM of the load/store unit, top level
// One write and one read request per cycle, each with lo and
// hi byte addresses; read data returns one cycle later
// Banks are interleaved on the word address
// ##########################################################

`timescale 1ns/100ps

module lsu_dccm_mem (
   input  logic                                 clk,
   input  logic                                 rst_n,

   // Request side
   input  logic                                 dccm_wren,
   input  logic                                 dccm_rden,
   input  logic [dccm_pkg::DCCM_BITS-1:0]       dccm_wr_addr_lo,
   input  logic [dccm_pkg::DCCM_BITS-1:0]       dccm_wr_addr_hi,
   input  logic [dccm_pkg::DCCM_BITS-1:0]       dccm_rd_addr_lo,
   // Upper word of a misaligned read
   input  logic [dccm_pkg::DCCM_BITS-1:0]       dccm_rd_addr_hi,
   input  logic [dccm_pkg::DCCM_DATA_WIDTH-1:0] dccm_wr_data_lo,
   input  logic [dccm_pkg::DCCM_DATA_WIDTH-1:0] dccm_wr_data_hi,

   // Read data, one cycle after dccm_rden
   output logic [dccm_pkg::DCCM_DATA_WIDTH-1:0] dccm_rd_data_lo,
   output logic [dccm_pkg::DCCM_DATA_WIDTH-1:0] dccm_rd_data_hi
);

   import dccm_pkg::*;

   // Per-bank controls from the steering block
   logic [DCCM_NUM_BANKS-1:0]                       wren_bank;
   logic [DCCM_NUM_BANKS-1:0]                       rden_bank;
   logic [DCCM_NUM_BANKS-1:0]                       clken_bank;
   logic [DCCM_NUM_BANKS-1:0][DCCM_INDEX_BITS-1:0]  addr_bank;
   logic [DCCM_NUM_BANKS-1:0][DCCM_DATA_WIDTH-1:0]  wr_data_bank;

   // Raw bank outputs, before alignment
   logic [DCCM_NUM_BANKS-1:0][DCCM_DATA_WIDTH-1:0]  bank_dout;

   // Address decode and bank steering
   dccm_bank_steer i_dccm_bank_steer (
      .dccm_wren       (dccm_wren),
      .dccm_rden       (dccm_rden),
      .dccm_wr_addr_lo (dccm_wr_addr_lo),
      .dccm_wr_addr_hi (dccm_wr_addr_hi),
      .dccm_rd_addr_lo (dccm_rd_addr_lo),
      .dccm_rd_addr_hi (dccm_rd_addr_hi),
      .dccm_wr_data_lo (dccm_wr_data_lo),
      .dccm_wr_data_hi (dccm_wr_data_hi),
      .wren_bank       (wren_bank),
      .rden_bank       (rden_bank),
      .clken_bank      (clken_bank),
      .addr_bank       (addr_bank),
      .wr_data_bank    (wr_data_bank)
   );

   // Bank array
   // rden_bank only feeds the chip enable, already folded into clken_bank
   for (genvar i = 0; i < DCCM_NUM_BANKS; i++) begin : g_mem_bank
      dccm_sram_bank i_dccm_sram_bank (
         .clk (clk),
         .me  (clken_bank[i]),
         .we  (wren_bank[i]),
         .adr (addr_bank[i]),
         .d   (wr_data_bank[i]),
         .q   (bank_dout[i])
      );
   end : g_mem_bank

   // Realign lo/hi words from the registered bank selects
   dccm_rd_align i_dccm_rd_align (
      .clk             (clk),
      .rst_n           (rst_n),
      .dccm_rd_addr_lo (dccm_rd_addr_lo),
      .dccm_rd_addr_hi (dccm_rd_addr_hi),
      .bank_dout       (bank_dout),
      .dccm_rd_data_lo (dccm_rd_data_lo),
      .dccm_rd_data_hi (dccm_rd_data_hi)
   );

endmodule

//--- bench/lsu_dccm_mem_sva.sv
// ##########################################################
// Concurrent assertions for the DCCM top level
// Bound onto lsu_dccm_mem; watches bank enables and read data
// ##########################################################

`timescale 1ns/100ps

module lsu_dccm_mem_sva (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic                                 dccm_wren,
   input  logic                                 dccm_rden,
   input  logic [dccm_pkg::DCCM_BITS-1:0]       dccm_wr_addr_lo,
   input  logic [dccm_pkg::DCCM_BITS-1:0]       dccm_wr_addr_hi,
   input  logic [dccm_pkg::DCCM_BITS-1:0]       dccm_rd_addr_lo,
   input  logic [dccm_pkg::DCCM_BITS-1:0]       dccm_rd_addr_hi,
   input  logic [dccm_pkg::DCCM_NUM_BANKS-1:0]  wren_bank,
   input  logic [dccm_pkg::DCCM_NUM_BANKS-1:0]  rden_bank,
   input  logic [dccm_pkg::DCCM_NUM_BANKS-1:0]  clken_bank,
   input  logic [dccm_pkg::DCCM_NUM_BANKS-1:0][dccm_pkg::DCCM_INDEX_BITS-1:0] addr_bank,
   input  logic [dccm_pkg::DCCM_DATA_WIDTH-1:0] dccm_rd_data_lo,
   input  logic [dccm_pkg::DCCM_DATA_WIDTH-1:0] dccm_rd_data_hi
);

   import dccm_pkg::*;

   // One flag per bank row that has seen a write
   logic [DCCM_NUM_BANKS-1:0][DCCM_INDEX_DEPTH-1:0] row_written;

   // Row of each read word has been written before
   logic lo_seen;
   logic hi_seen;

   // Banks that the current request addresses land in
   logic [DCCM_NUM_BANKS-1:0] exp_wren;
   logic [DCCM_NUM_BANKS-1:0] exp_rden;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         row_written <= '0;
      end else begin
         for (int i = 0; i < DCCM_NUM_BANKS; i++) begin
            if (wren_bank[i]) begin
               row_written[i][addr_bank[i]] <= 1'b1;
            end
         end
      end
   end

   assign lo_seen = row_written[dccm_rd_addr_lo[DCCM_WIDTH_BITS +: DCCM_BANK_BITS]]
                               [dccm_rd_addr_lo[DCCM_INDEX_LSB +: DCCM_INDEX_BITS]];
   assign hi_seen = row_written[dccm_rd_addr_hi[DCCM_WIDTH_BITS +: DCCM_BANK_BITS]]
                               [dccm_rd_addr_hi[DCCM_INDEX_LSB +: DCCM_INDEX_BITS]];

   // Mark the bank of each lo and hi address
   always_comb begin
      exp_wren = '0;
      exp_rden = '0;
      if (dccm_wren) begin
         exp_wren[dccm_wr_addr_lo[DCCM_WIDTH_BITS +: DCCM_BANK_BITS]] = 1'b1;
         exp_wren[dccm_wr_addr_hi[DCCM_WIDTH_BITS +: DCCM_BANK_BITS]] = 1'b1;
      end
      if (dccm_rden) begin
         exp_rden[dccm_rd_addr_lo[DCCM_WIDTH_BITS +: DCCM_BANK_BITS]] = 1'b1;
         exp_rden[dccm_rd_addr_hi[DCCM_WIDTH_BITS +: DCCM_BANK_BITS]] = 1'b1;
      end
   end

   // A request touches at most two adjacent words
   a_wr_two_banks : assert property (@(posedge clk) disable iff (!rst_n)
      $countones(wren_bank) <= 2)
      else $error("more than two banks write-enabled");

   a_rd_two_banks : assert property (@(posedge clk) disable iff (!rst_n)
      $countones(rden_bank) <= 2)
      else $error("more than two banks read-enabled");

   // Chip enable covers the write banks and the read banks of the request
   a_clken : assert property (@(posedge clk) disable iff (!rst_n)
      clken_bank == (exp_wren | exp_rden))
      else $error("bank chip enable does not match the request addresses");

   // Written rows come back as known data
   a_rd_lo_known : assert property (@(posedge clk) disable iff (!rst_n)
      (dccm_rden && lo_seen) |=> !$isunknown(dccm_rd_data_lo))
      else $error("lo read data unknown after read of a written row");

   a_rd_hi_known : assert property (@(posedge clk) disable iff (!rst_n)
      (dccm_rden && hi_seen) |=> !$isunknown(dccm_rd_data_hi))
      else $error("hi read data unknown after read of a written row");

endmodule

bind lsu_dccm_mem lsu_dccm_mem_sva i_lsu_dccm_mem_sva (
   .clk             (clk),
   .rst_n           (rst_n),
   .dccm_wren       (dccm_wren),
   .dccm_rden       (dccm_rden),
   .dccm_wr_addr_lo (dccm_wr_addr_lo),
   .dccm_wr_addr_hi (dccm_wr_addr_hi),
   .dccm_rd_addr_lo (dccm_rd_addr_lo),
   .dccm_rd_addr_hi (dccm_rd_addr_hi),
   .wren_bank       (wren_bank),
   .rden_bank       (rden_bank),
   .clken_bank      (clken_bank),
   .addr_bank       (addr_bank),
   .dccm_rd_data_lo (dccm_rd_data_lo),
   .dccm_rd_data_hi (dccm_rd_data_hi)
);

//--- bench/tb_lsu_dccm_mem.sv
// ##########################################################
// Testbench for the DCCM top level
// Applies a table of fixed and random requests, one per
// cycle, and checks read data against a word-level model
// ##########################################################

`timescale 1ns/100ps

module tb_lsu_dccm_mem;

   import dccm_pkg::*;

   localparam int NUM_ENTRIES    = 64;
   localparam int NUM_FIXED      = 16;
   localparam int RESET_CYCLES   = 10;
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ENTRIES * 2 + 50;
   localparam int NUM_WORDS      = 1 << (DCCM_BITS - DCCM_WIDTH_BITS);
   localparam logic [31:0] SEED  = 32'he3c2_72dc;
   // Random window, small so that reads hit written words
   localparam int RAND_BASE      = 'h100;
   localparam int RAND_SPAN      = 'h80;

   logic                       clk;
   logic                       rst_n;
   logic                       dccm_wren;
   logic                       dccm_rden;
   logic [DCCM_BITS-1:0]       dccm_wr_addr_lo;
   logic [DCCM_BITS-1:0]       dccm_wr_addr_hi;
   logic [DCCM_BITS-1:0]       dccm_rd_addr_lo;
   logic [DCCM_BITS-1:0]       dccm_rd_addr_hi;
   logic [DCCM_DATA_WIDTH-1:0] dccm_wr_data_lo;
   logic [DCCM_DATA_WIDTH-1:0] dccm_wr_data_hi;
   logic [DCCM_DATA_WIDTH-1:0] dccm_rd_data_lo;
   logic [DCCM_DATA_WIDTH-1:0] dccm_rd_data_hi;

   // Stimulus table
   bit                         tbl_wren  [NUM_ENTRIES];
   bit                         tbl_rden  [NUM_ENTRIES];
   logic [DCCM_BITS-1:0]       tbl_wr_lo [NUM_ENTRIES];
   logic [DCCM_BITS-1:0]       tbl_wr_hi [NUM_ENTRIES];
   logic [DCCM_BITS-1:0]       tbl_rd_lo [NUM_ENTRIES];
   logic [DCCM_BITS-1:0]       tbl_rd_hi [NUM_ENTRIES];
   logic [DCCM_DATA_WIDTH-1:0] tbl_wd_lo [NUM_ENTRIES];
   logic [DCCM_DATA_WIDTH-1:0] tbl_wd_hi [NUM_ENTRIES];

   // Reference memory, one word per 4-byte address
   logic [DCCM_DATA_WIDTH-1:0] ref_mem   [NUM_WORDS];
   bit                         ref_valid [NUM_WORDS];

   // Expected result of the read issued last cycle
   bit                         pend_rd;
   bit                         pend_chk_lo;
   bit                         pend_chk_hi;
   logic [DCCM_DATA_WIDTH-1:0] pend_lo;
   logic [DCCM_DATA_WIDTH-1:0] pend_hi;
   int                         pend_entry;

   int                         error_count = 0;
   int                         check_count = 0;
   int                         cycle_count = 0;
   logic [31:0]                seed_ret;

   lsu_dccm_mem i_lsu_dccm_mem (
      .clk             (clk),
      .rst_n           (rst_n),
      .dccm_wren       (dccm_wren),
      .dccm_rden       (dccm_rden),
      .dccm_wr_addr_lo (dccm_wr_addr_lo),
      .dccm_wr_addr_hi (dccm_wr_addr_hi),
      .dccm_rd_addr_lo (dccm_rd_addr_lo),
      .dccm_rd_addr_hi (dccm_rd_addr_hi),
      .dccm_wr_data_lo (dccm_wr_data_lo),
      .dccm_wr_data_hi (dccm_wr_data_hi),
      .dccm_rd_data_lo (dccm_rd_data_lo),
      .dccm_rd_data_hi (dccm_rd_data_hi)
   );

   // 4 ns clock
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Hang guard
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Run timed out after %0d cycles without finishing", cycle_count);
         $display("TEST FAILED");
         $finish;
      end
   end

   // Hi address is lo, or the next word with wrap at the top
   function automatic logic [DCCM_BITS-1:0] hi_addr(input logic [DCCM_BITS-1:0] lo,
                                                    input bit mis);
      return mis ? lo + DCCM_BITS'(DCCM_BYTE_WIDTH) : lo;
   endfunction

   function automatic int word_of(input logic [DCCM_BITS-1:0] a);
      return int'(a >> DCCM_WIDTH_BITS);
   endfunction

   function automatic int bank_of(input logic [DCCM_BITS-1:0] a);
      return int'(a[DCCM_WIDTH_BITS +: DCCM_BANK_BITS]);
   endfunction

   // True when the write and read requests share any bank
   function automatic bit banks_overlap(input int k);
      int wb_lo;
      int wb_hi;
      int rb_lo;
      int rb_hi;
      wb_lo = bank_of(tbl_wr_lo[k]);
      wb_hi = bank_of(tbl_wr_hi[k]);
      rb_lo = bank_of(tbl_rd_lo[k]);
      rb_hi = bank_of(tbl_rd_hi[k]);
      return (wb_lo == rb_lo) || (wb_lo == rb_hi) || (wb_hi == rb_lo) || (wb_hi == rb_hi);
   endfunction

   task automatic set_entry(input int k, input bit wr, input logic [DCCM_BITS-1:0] wr_lo,
                            input bit wr_mis, input logic [DCCM_DATA_WIDTH-1:0] d_lo,
                            input logic [DCCM_DATA_WIDTH-1:0] d_hi, input bit rd,
                            input logic [DCCM_BITS-1:0] rd_lo, input bit rd_mis);
      tbl_wren[k]  = wr;
      tbl_wr_lo[k] = wr_lo;
      tbl_wr_hi[k] = hi_addr(wr_lo, wr_mis);
      tbl_wd_lo[k] = d_lo;
      tbl_wd_hi[k] = d_hi;
      tbl_rden[k]  = rd;
      tbl_rd_lo[k] = rd_lo;
      tbl_rd_hi[k] = hi_addr(rd_lo, rd_mis);
   endtask

   task automatic load_fixed_entries();
      // Aligned write, then read back
      set_entry(0, 1, 'h100, 0, 32'hA5A5_0001, 32'h0, 0, 'h0, 0);
      set_entry(1, 0, 'h0, 0, 32'h0, 32'h0, 1, 'h100, 0);
      // Misaligned write into banks 1 and 2, each word read alone
      set_entry(2, 1, 'h204, 1, 32'hB0B0_0002, 32'hC0C0_0003, 0, 'h0, 0);
      set_entry(3, 0, 'h0, 0, 32'h0, 32'h0, 1, 'h204, 0);
      set_entry(4, 0, 'h0, 0, 32'h0, 32'h0, 1, 'h208, 0);
      // Last word of bank 3 and first word of bank 0
      set_entry(5, 1, 'hFFC, 0, 32'hD0D0_0004, 32'h0, 0, 'h0, 0);
      set_entry(6, 1, 'h000, 0, 32'hE0E0_0005, 32'h0, 0, 'h0, 0);
      // Misaligned read that wraps to address zero
      set_entry(7, 0, 'h0, 0, 32'h0, 32'h0, 1, 'hFFE, 1);
      // Reads back to back
      set_entry(8, 0, 'h0, 0, 32'h0, 32'h0, 1, 'h100, 0);
      set_entry(9, 0, 'h0, 0, 32'h0, 32'h0, 1, 'h204, 0);
      set_entry(10, 0, 'h0, 0, 32'h0, 32'h0, 1, 'h208, 0);
      set_entry(11, 0, 'h0, 0, 32'h0, 32'h0, 1, 'hFFC, 0);
      // Write bank 3 while reading banks 1 and 2
      set_entry(12, 1, 'h30C, 0, 32'hF0F0_0006, 32'h0, 1, 'h204, 1);
      set_entry(13, 0, 'h0, 0, 32'h0, 32'h0, 1, 'h30C, 0);
      // Misaligned write beside a bank 0 read
      set_entry(14, 1, 'h104, 1, 32'h1111_0007, 32'h2222_0008, 1, 'h100, 0);
      set_entry(15, 0, 'h0, 0, 32'h0, 32'h0, 1, 'h104, 1);
   endtask

   task automatic fill_random_entries();
      int kind;
      bit wr;
      bit rd;
      for (int k = NUM_FIXED; k < NUM_ENTRIES; k++) begin
         kind = $urandom % 3;
         wr = (kind != 1);
         rd = (kind != 0);
         set_entry(k, wr, DCCM_BITS'(RAND_BASE + $urandom % RAND_SPAN), $urandom % 2,
                   $urandom, $urandom, rd, DCCM_BITS'(RAND_BASE + $urandom % RAND_SPAN),
                   $urandom % 2);
         // Same bank for read and write is not allowed, keep the read
         if (wr && rd && banks_overlap(k)) begin
            tbl_wren[k] = 1'b0;
         end
      end
   endtask

   // Drive one table entry and update the model
   task automatic apply_entry(input int k);
      dccm_wren       = tbl_wren[k];
      dccm_rden       = tbl_rden[k];
      dccm_wr_addr_lo = tbl_wr_lo[k];
      dccm_wr_addr_hi = tbl_wr_hi[k];
      dccm_rd_addr_lo = tbl_rd_lo[k];
      dccm_rd_addr_hi = tbl_rd_hi[k];
      dccm_wr_data_lo = tbl_wd_lo[k];
      dccm_wr_data_hi = tbl_wd_hi[k];
      pend_rd    = tbl_rden[k];
      pend_entry = k;
      if (tbl_rden[k]) begin
         pend_chk_lo = ref_valid[word_of(tbl_rd_lo[k])];
         pend_chk_hi = ref_valid[word_of(tbl_rd_hi[k])];
         pend_lo     = ref_mem[word_of(tbl_rd_lo[k])];
         pend_hi     = ref_mem[word_of(tbl_rd_hi[k])];
      end
      if (tbl_wren[k]) begin
         ref_mem[word_of(tbl_wr_lo[k])]   = tbl_wd_lo[k];
         ref_valid[word_of(tbl_wr_lo[k])] = 1'b1;
         // Second word only when lo and hi sit in different banks
         if (bank_of(tbl_wr_lo[k]) != bank_of(tbl_wr_hi[k])) begin
            ref_mem[word_of(tbl_wr_hi[k])]   = tbl_wd_hi[k];
            ref_valid[word_of(tbl_wr_hi[k])] = 1'b1;
         end
      end
   endtask

   // Compare the read issued one cycle ago
   task automatic check_pending();
      if (pend_rd && pend_chk_lo) begin
         check_count++;
         if (dccm_rd_data_lo !== pend_lo) begin
            error_count++;
            $display("Error at %0t: entry %0d lo read data %h, expected %h",
                     $time, pend_entry, dccm_rd_data_lo, pend_lo);
         end
      end
      if (pend_rd && pend_chk_hi) begin
         check_count++;
         if (dccm_rd_data_hi !== pend_hi) begin
            error_count++;
            $display("Error at %0t: entry %0d hi read data %h, expected %h",
                     $time, pend_entry, dccm_rd_data_hi, pend_hi);
         end
      end
      pend_rd = 1'b0;
   endtask

   initial begin
      rst_n           = 1'b0;
      dccm_wren       = 1'b0;
      dccm_rden       = 1'b0;
      dccm_wr_addr_lo = '0;
      dccm_wr_addr_hi = '0;
      dccm_rd_addr_lo = '0;
      dccm_rd_addr_hi = '0;
      dccm_wr_data_lo = '0;
      dccm_wr_data_hi = '0;
      pend_rd         = 1'b0;
      seed_ret        = $urandom(SEED);
      load_fixed_entries();
      fill_random_entries();

      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // One entry per cycle, results checked on the next falling edge
      for (int k = 0; k < NUM_ENTRIES; k++) begin
         @(negedge clk);
         check_pending();
         apply_entry(k);
      end
      @(negedge clk);
      check_pending();
      dccm_wren = 1'b0;
      dccm_rden = 1'b0;
      repeat (2) @(negedge clk);

      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- project.f
src/dccm_pkg.sv
src/dccm_bank_steer.sv
src/dccm_sram_bank.sv
src/dccm_rd_align.sv
src/lsu_dccm_mem.sv
bench/lsu_dccm_mem_sva.sv
bench/tb_lsu_dccm_mem.sv
